// ==== verilog/eth_demux_defs.svh ====
/*
 * width and port-count macros for the four-way Ethernet demultiplexer
 * payload beat widths, port count and index width, header field widths
 */

`ifndef ETH_DEMUX_DEFS_SVH
`define ETH_DEMUX_DEFS_SVH

// payload path
`define ETH_DATA_WIDTH 64
`define ETH_KEEP_WIDTH 8

// output ports, ETH_SEL_WIDTH must cover ETH_NUM_PORTS
`define ETH_NUM_PORTS 4
`define ETH_SEL_WIDTH 2

// header fields
`define ETH_MAC_WIDTH 48
`define ETH_TYPE_WIDTH 16

`endif

// ==== verilog/eth_hdr_pkg.sv ====
/*
 * Ethernet header field types
 * MAC address, ethertype and the full 112-bit header struct
 */

`default_nettype none

`include "eth_demux_defs.svh"

package eth_hdr_pkg;

    typedef logic [`ETH_MAC_WIDTH-1:0] mac_addr_t;

    typedef logic [`ETH_TYPE_WIDTH-1:0] ether_type_t;

    // field order follows the wire order of the frame
    typedef struct packed {
        mac_addr_t   dest_mac;
        mac_addr_t   src_mac;
        ether_type_t eth_type;
    } eth_hdr_t;

endpackage

`default_nettype wire

// ==== verilog/eth_stream_pkg.sv ====
/*
 * payload stream types
 * one 73-bit payload beat (data, keep, last) and the output port index
 */

`default_nettype none

`include "eth_demux_defs.svh"

package eth_stream_pkg;

    // one payload beat, keep holds byte enables for data
    typedef struct packed {
        logic [`ETH_DATA_WIDTH-1:0] data;
        logic [`ETH_KEEP_WIDTH-1:0] keep;
        logic                       last;
    } beat_t;

    // index of one demultiplexer output
    typedef logic [`ETH_SEL_WIDTH-1:0] port_sel_t;

endpackage

`default_nettype wire

// ==== verilog/eth_port_if.sv ====
/*
 * link between the frame controller and one output port controller
 * ctrl side drives grant strobe, latched port and beat valid
 * port side reports header valid, payload valid and output ready
 */

`timescale 1ns/1ps
`default_nettype none

interface eth_port_if;
    import eth_stream_pkg::*;

    // from the frame controller
    logic      hdr_start;
    port_sel_t cur_port;
    logic      beat_valid;

    // from the port controller
    logic      hdr_valid;
    logic      tvalid;
    logic      tready;

    modport ctrl (
        output hdr_start, cur_port, beat_valid,
        input  hdr_valid, tvalid, tready
    );

    modport port (
        input  hdr_start, cur_port, beat_valid,
        output hdr_valid, tvalid, tready
    );

endinterface

`default_nettype wire

// ==== verilog/eth_frame_ctrl.sv ====
/*
 * frame controller for the Ethernet demultiplexer
 * frame flag, select latch and registered header capture
 * registered header and payload input readies
 * mux of the current output's valid and ready, beat forwarding to the skid buffer
 */

`timescale 1ns/1ps
`default_nettype none

`include "eth_demux_defs.svh"

module eth_frame_ctrl (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     enable,
    input  eth_stream_pkg::port_sel_t select,
    input  logic                     in_hdr_valid,
    output logic                     in_hdr_ready,
    input  eth_hdr_pkg::eth_hdr_t    in_hdr,
    input  eth_stream_pkg::beat_t    in_beat,
    input  logic                     in_tvalid,
    output logic                     in_tready,
    output eth_hdr_pkg::eth_hdr_t    out_hdr,
    output eth_stream_pkg::beat_t    skid_beat,
    output logic                     skid_valid,
    input  logic                     skid_ready_early,
    input  logic                     beat_valid,
    output logic                     cur_tready,
    output logic                     cur_tvalid,
    eth_port_if.ctrl                 ports [`ETH_NUM_PORTS]
);
    import eth_stream_pkg::*;

    logic      frame_reg;
    logic      frame_next;
    port_sel_t cur_port_reg;
    logic      hdr_ready_reg;
    logic      tready_reg;
    logic      grant;
    logic      beat_accept;

    logic [`ETH_NUM_PORTS-1:0] hdr_valid_vec;
    logic [`ETH_NUM_PORTS-1:0] tvalid_vec;
    logic [`ETH_NUM_PORTS-1:0] tready_vec;

    // the header ready pulse doubles as the grant strobe to the ports
    for (genvar i = 0; i < `ETH_NUM_PORTS; i++) begin : g_link
        assign ports[i].hdr_start  = hdr_ready_reg;
        assign ports[i].cur_port   = cur_port_reg;
        assign ports[i].beat_valid = beat_valid;
        assign hdr_valid_vec[i]    = ports[i].hdr_valid;
        assign tvalid_vec[i]       = ports[i].tvalid;
        assign tready_vec[i]       = ports[i].tready;
    end

    assign cur_tready = tready_vec[cur_port_reg];
    assign cur_tvalid = tvalid_vec[cur_port_reg];

    // new frame only once the previous port has drained header and payload
    assign grant = ~frame_reg & enable & in_hdr_valid &
                   ~hdr_valid_vec[cur_port_reg] & ~cur_tvalid;

    assign beat_accept = in_tvalid & tready_reg;

    always_comb begin
        frame_next = frame_reg;
        if (grant) begin
            frame_next = 1'b1;
        end else if (frame_reg && beat_accept && in_beat.last) begin
            // end of frame
            frame_next = 1'b0;
        end
    end

    assign skid_beat    = in_beat;
    assign skid_valid   = beat_accept;
    assign in_hdr_ready = hdr_ready_reg;
    assign in_tready    = tready_reg;

    always_ff @(posedge clk) begin
        if (rst) begin
            frame_reg     <= 1'b0;
            cur_port_reg  <= '0;
            hdr_ready_reg <= 1'b0;
            tready_reg    <= 1'b0;
        end else begin
            frame_reg     <= frame_next;
            hdr_ready_reg <= grant;
            tready_reg    <= skid_ready_early & frame_next;
            if (grant) begin
                cur_port_reg <= select;
            end
        end

        if (grant) begin
            out_hdr <= in_hdr;
        end
    end

endmodule

`default_nettype wire

// ==== verilog/eth_beat_skid.sv ====
/*
 * two-register skid buffer for the payload beats
 * output register plus temp register, early ready and its registered copy
 * keeps the payload at full rate while the current output stalls
 */

`timescale 1ns/1ps
`default_nettype none

module eth_beat_skid (
    input  logic                  clk,
    input  logic                  rst,
    input  eth_stream_pkg::beat_t in_beat,
    input  logic                  in_valid,
    output logic                  ready_early,
    input  logic                  cur_tready,
    input  logic                  cur_tvalid,
    output eth_stream_pkg::beat_t out_beat,
    output logic                  beat_valid
);
    import eth_stream_pkg::*;

    logic  ready_reg;
    logic  temp_valid;
    beat_t temp_beat;

    logic  out_valid_next;
    logic  temp_valid_next;
    logic  load_out_from_in;
    logic  load_out_from_temp;
    logic  load_temp_from_in;

    // ready next cycle unless the temp register could fill up
    assign ready_early = cur_tready | (~temp_valid & (~cur_tvalid | ~in_valid));

    always_comb begin
        out_valid_next     = beat_valid;
        temp_valid_next    = temp_valid;
        load_out_from_in   = 1'b0;
        load_out_from_temp = 1'b0;
        load_temp_from_in  = 1'b0;

        if (ready_reg) begin
            if (cur_tready | ~cur_tvalid) begin
                // output free, input goes straight out
                out_valid_next   = in_valid;
                load_out_from_in = 1'b1;
            end else begin
                // output stalled, park the input beat
                temp_valid_next   = in_valid;
                load_temp_from_in = 1'b1;
            end
        end else if (cur_tready) begin
            // input closed, drain temp into the output register
            out_valid_next     = temp_valid;
            temp_valid_next    = 1'b0;
            load_out_from_temp = 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            ready_reg  <= 1'b0;
            temp_valid <= 1'b0;
            beat_valid <= 1'b0;
        end else begin
            ready_reg  <= ready_early;
            temp_valid <= temp_valid_next;
            beat_valid <= out_valid_next;
        end

        if (load_out_from_in) begin
            out_beat <= in_beat;
        end else if (load_out_from_temp) begin
            out_beat <= temp_beat;
        end

        if (load_temp_from_in) begin
            temp_beat <= in_beat;
        end
    end

endmodule

`default_nettype wire

// ==== verilog/eth_port_ctrl.sv ====
/*
 * per-output port controller
 * header valid register set by the grant strobe, cleared by header ready
 * payload valid gated by the latched port match
 */

`timescale 1ns/1ps
`default_nettype none

module eth_port_ctrl #(
    parameter eth_stream_pkg::port_sel_t port_index = '0
) (
    input  logic     clk,
    input  logic     rst,
    eth_port_if.port link,
    input  logic     hdr_ready,
    output logic     hdr_valid,
    input  logic     tready,
    output logic     tvalid
);

    logic selected;
    logic hdr_valid_reg;

    assign selected = (link.cur_port == port_index);

    // valid already in the strobe cycle, the register holds it afterwards
    assign hdr_valid = hdr_valid_reg | (link.hdr_start & selected);

    always_ff @(posedge clk) begin
        if (rst) begin
            hdr_valid_reg <= 1'b0;
        end else begin
            hdr_valid_reg <= hdr_valid & ~hdr_ready;
        end
    end

    assign tvalid = link.beat_valid & selected;

    // report back to the frame controller
    assign link.hdr_valid = hdr_valid;
    assign link.tvalid    = tvalid;
    assign link.tready    = tready;

endmodule

`default_nettype wire

// ==== verilog/eth_demux_top.sv ====
/*
 * four-way Ethernet frame demultiplexer, 64-bit payload path
 * plain top-level ports packed into header and beat structs
 * frame controller, payload skid buffer, one port controller per output
 */

`timescale 1ns/1ps
`default_nettype none

`include "eth_demux_defs.svh"

module eth_demux_top (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       enable,
    input  logic [`ETH_SEL_WIDTH-1:0]  select,

    // frame input
    input  logic                       in_hdr_valid,
    output logic                       in_hdr_ready,
    input  logic [`ETH_MAC_WIDTH-1:0]  in_dest_mac,
    input  logic [`ETH_MAC_WIDTH-1:0]  in_src_mac,
    input  logic [`ETH_TYPE_WIDTH-1:0] in_eth_type,
    input  logic [`ETH_DATA_WIDTH-1:0] in_tdata,
    input  logic [`ETH_KEEP_WIDTH-1:0] in_tkeep,
    input  logic                       in_tvalid,
    output logic                       in_tready,
    input  logic                       in_tlast,

    // frame outputs, one handshake bit per port
    output logic [`ETH_NUM_PORTS-1:0]  out_hdr_valid,
    input  logic [`ETH_NUM_PORTS-1:0]  out_hdr_ready,
    output logic [`ETH_NUM_PORTS-1:0]  out_tvalid,
    input  logic [`ETH_NUM_PORTS-1:0]  out_tready,

    // shared by all outputs
    output logic [`ETH_MAC_WIDTH-1:0]  out_dest_mac,
    output logic [`ETH_MAC_WIDTH-1:0]  out_src_mac,
    output logic [`ETH_TYPE_WIDTH-1:0] out_eth_type,
    output logic [`ETH_DATA_WIDTH-1:0] out_tdata,
    output logic [`ETH_KEEP_WIDTH-1:0] out_tkeep,
    output logic                       out_tlast
);
    import eth_hdr_pkg::*;
    import eth_stream_pkg::*;

    eth_hdr_t in_hdr;
    eth_hdr_t out_hdr;
    beat_t    in_beat;
    beat_t    skid_beat;
    beat_t    out_beat;
    logic     skid_valid;
    logic     skid_ready_early;
    logic     beat_valid;
    logic     cur_tready;
    logic     cur_tvalid;

    eth_port_if port_link [`ETH_NUM_PORTS] ();

    assign in_hdr.dest_mac = in_dest_mac;
    assign in_hdr.src_mac  = in_src_mac;
    assign in_hdr.eth_type = in_eth_type;
    assign in_beat.data    = in_tdata;
    assign in_beat.keep    = in_tkeep;
    assign in_beat.last    = in_tlast;

    assign out_dest_mac = out_hdr.dest_mac;
    assign out_src_mac  = out_hdr.src_mac;
    assign out_eth_type = out_hdr.eth_type;
    assign out_tdata    = out_beat.data;
    assign out_tkeep    = out_beat.keep;
    assign out_tlast    = out_beat.last;

    eth_frame_ctrl i_frame_ctrl (
        .clk              (clk),
        .rst              (rst),
        .enable           (enable),
        .select           (port_sel_t'(select)),
        .in_hdr_valid     (in_hdr_valid),
        .in_hdr_ready     (in_hdr_ready),
        .in_hdr           (in_hdr),
        .in_beat          (in_beat),
        .in_tvalid        (in_tvalid),
        .in_tready        (in_tready),
        .out_hdr          (out_hdr),
        .skid_beat        (skid_beat),
        .skid_valid       (skid_valid),
        .skid_ready_early (skid_ready_early),
        .beat_valid       (beat_valid),
        .cur_tready       (cur_tready),
        .cur_tvalid       (cur_tvalid),
        .ports            (port_link)
    );

    eth_beat_skid i_beat_skid (
        .clk         (clk),
        .rst         (rst),
        .in_beat     (skid_beat),
        .in_valid    (skid_valid),
        .ready_early (skid_ready_early),
        .cur_tready  (cur_tready),
        .cur_tvalid  (cur_tvalid),
        .out_beat    (out_beat),
        .beat_valid  (beat_valid)
    );

    for (genvar i = 0; i < `ETH_NUM_PORTS; i++) begin : g_port
        eth_port_ctrl #(
            .port_index (port_sel_t'(i))
        ) i_port_ctrl (
            .clk       (clk),
            .rst       (rst),
            .link      (port_link[i]),
            .hdr_ready (out_hdr_ready[i]),
            .hdr_valid (out_hdr_valid[i]),
            .tready    (out_tready[i]),
            .tvalid    (out_tvalid[i])
        );
    end

endmodule

`default_nettype wire

// ==== verification/tb_clk_gen.sv ====
/*
 * testbench clock and reset source
 * 40 ns clock, reset held high for two cycles and released on a falling edge
 */

`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    initial begin
        rst = 1'b1;
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
    end

endmodule

`default_nettype wire

// ==== verification/tb_eth_demux.sv ====
/*
 * testbench for the four-way Ethernet frame demultiplexer
 * LFSR stimulus, expected header and beat queues, per-cycle output checks
 * tests: reset, routing, enable hold-off, back-pressure, exclusivity
 */

`timescale 1ns/1ps
`default_nettype none

`include "eth_demux_defs.svh"

module tb_eth_demux;

    localparam int TIMEOUT = 400;

    typedef struct packed {
        logic [`ETH_SEL_WIDTH-1:0]  port;
        logic [`ETH_MAC_WIDTH-1:0]  dest;
        logic [`ETH_MAC_WIDTH-1:0]  src;
        logic [`ETH_TYPE_WIDTH-1:0] etype;
    } exp_hdr_t;

    typedef struct packed {
        logic [`ETH_SEL_WIDTH-1:0]  port;
        logic [`ETH_DATA_WIDTH-1:0] data;
        logic [`ETH_KEEP_WIDTH-1:0] keep;
        logic                       last;
    } exp_beat_t;

    logic                       clk;
    logic                       rst;
    logic                       enable;
    logic [`ETH_SEL_WIDTH-1:0]  select;
    logic                       in_hdr_valid;
    logic                       in_hdr_ready;
    logic [`ETH_MAC_WIDTH-1:0]  in_dest_mac;
    logic [`ETH_MAC_WIDTH-1:0]  in_src_mac;
    logic [`ETH_TYPE_WIDTH-1:0] in_eth_type;
    logic [`ETH_DATA_WIDTH-1:0] in_tdata;
    logic [`ETH_KEEP_WIDTH-1:0] in_tkeep;
    logic                       in_tvalid;
    logic                       in_tready;
    logic                       in_tlast;
    logic [`ETH_NUM_PORTS-1:0]  out_hdr_valid;
    logic [`ETH_NUM_PORTS-1:0]  out_hdr_ready;
    logic [`ETH_NUM_PORTS-1:0]  out_tvalid;
    logic [`ETH_NUM_PORTS-1:0]  out_tready;
    logic [`ETH_MAC_WIDTH-1:0]  out_dest_mac;
    logic [`ETH_MAC_WIDTH-1:0]  out_src_mac;
    logic [`ETH_TYPE_WIDTH-1:0] out_eth_type;
    logic [`ETH_DATA_WIDTH-1:0] out_tdata;
    logic [`ETH_KEEP_WIDTH-1:0] out_tkeep;
    logic                       out_tlast;

    // expected headers and beats in send order across all outputs
    exp_hdr_t  hdr_q [$];
    exp_beat_t beat_q [$];

    logic [31:0] lfsr_state = 32'h0d30_d574;
    logic        random_ready = 1'b0;
    logic        hdr_ready_prev = 1'b0;
    logic        timed_out = 1'b0;
    int          error_count = 0;
    int          excl_errors = 0;
    int          tests_run = 0;
    int          tests_failed = 0;
    int          hdrs_checked = 0;
    int          beats_checked = 0;
    int          cycle_count = 0;

    tb_clk_gen i_clk_gen (.clk(clk), .rst(rst));

    eth_demux_top i_eth_demux_top (.*);

    // Galois form of x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] state);
        if (state[0]) begin
            return (state >> 1) ^ 32'h8020_0003;
        end
        return state >> 1;
    endfunction

    task automatic random_bits(input int nbits, output logic [63:0] value);
        int i;
        value = '0;
        for (i = 0; i < nbits; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            value = {value[62:0], lfsr_state[0]};
        end
    endtask

    function automatic logic [`ETH_NUM_PORTS-1:0] port_mask(input logic [`ETH_SEL_WIDTH-1:0] p);
        logic [`ETH_NUM_PORTS-1:0] mask;
        mask = '0;
        mask[p] = 1'b1;
        return mask;
    endfunction

    task automatic log_error(input string msg);
        $display("[ERROR] %0t ns: %s", $time, msg);
        error_count++;
    endtask

    task automatic compare_header();
        exp_hdr_t                  want;
        logic [`ETH_NUM_PORTS-1:0] fire;
        fire = out_hdr_valid & out_hdr_ready;
        if (fire != '0) begin
            if (hdr_q.size() == 0) begin
                log_error($sformatf("header handshake on ports %b with none expected", fire));
            end else begin
                want = hdr_q.pop_front();
                hdrs_checked++;
                if (fire != port_mask(want.port)) begin
                    log_error($sformatf("header on ports %b, expected port %0d", fire, want.port));
                end
                if (out_dest_mac != want.dest || out_src_mac != want.src ||
                    out_eth_type != want.etype) begin
                    log_error($sformatf("header %h %h %h, expected %h %h %h", out_dest_mac,
                              out_src_mac, out_eth_type, want.dest, want.src, want.etype));
                end
            end
        end
    endtask

    task automatic compare_beat();
        exp_beat_t                 want;
        logic [`ETH_NUM_PORTS-1:0] fire;
        fire = out_tvalid & out_tready;
        if (fire != '0) begin
            if (beat_q.size() == 0) begin
                log_error($sformatf("payload beat on ports %b with none expected", fire));
            end else begin
                want = beat_q.pop_front();
                beats_checked++;
                if (fire != port_mask(want.port)) begin
                    log_error($sformatf("beat on ports %b, expected port %0d", fire, want.port));
                end
                if (out_tdata != want.data || out_tkeep != want.keep || out_tlast != want.last) begin
                    log_error($sformatf("beat %h/%h/%b, expected %h/%h/%b", out_tdata, out_tkeep,
                              out_tlast, want.data, want.keep, want.last));
                end
            end
        end
    endtask

    // one clock cycle with new output readies on the falling edge before the checks
    task automatic next_cycle();
        logic [63:0] r;
        @(negedge clk);
        cycle_count++;
        if (random_ready) begin
            random_bits(`ETH_NUM_PORTS, r);
            out_tready = r[`ETH_NUM_PORTS-1:0];
            random_bits(`ETH_NUM_PORTS, r);
            out_hdr_ready = r[`ETH_NUM_PORTS-1:0];
        end else begin
            out_tready = '1;
            out_hdr_ready = '1;
        end
        if ($countones(out_hdr_valid) > 1 || $countones(out_tvalid) > 1) begin
            excl_errors++;
            log_error($sformatf("several outputs valid, hdr %b payload %b", out_hdr_valid,
                      out_tvalid));
        end
        if (in_hdr_ready && hdr_ready_prev) begin
            excl_errors++;
            log_error("in_hdr_ready high for more than one cycle");
        end
        hdr_ready_prev = in_hdr_ready;
        compare_header();
        compare_beat();
    endtask

    task automatic present_header(input logic [`ETH_SEL_WIDTH-1:0] port);
        logic [63:0] r;
        exp_hdr_t    want;
        want.port = port;
        random_bits(`ETH_MAC_WIDTH, r);
        want.dest = r[`ETH_MAC_WIDTH-1:0];
        random_bits(`ETH_MAC_WIDTH, r);
        want.src = r[`ETH_MAC_WIDTH-1:0];
        random_bits(`ETH_TYPE_WIDTH, r);
        want.etype = r[`ETH_TYPE_WIDTH-1:0];
        select = port;
        in_dest_mac = want.dest;
        in_src_mac = want.src;
        in_eth_type = want.etype;
        in_hdr_valid = 1'b1;
        hdr_q.push_back(want);
    endtask

    task automatic await_header();
        int count;
        count = 0;
        while (!in_hdr_ready && count < TIMEOUT) begin
            next_cycle();
            count++;
        end
        if (!in_hdr_ready) begin
            timed_out = 1'b1;
            $display("timeout: header not accepted within %0d cycles", TIMEOUT);
        end else begin
            // the input transfer completes on the coming rising edge
            next_cycle();
            in_hdr_valid = 1'b0;
        end
    endtask

    task automatic send_payload(input logic [`ETH_SEL_WIDTH-1:0] port, input int nbeats,
                                input logic gaps);
        logic [63:0] r;
        exp_beat_t   want;
        int          beat;
        int          idle;
        int          count;
        for (beat = 0; beat < nbeats && !timed_out; beat++) begin
            random_bits(3, r);
            idle = (gaps && r[2]) ? int'(r[1:0]) : 0;
            in_tvalid = 1'b0;
            repeat (idle) next_cycle();
            want.port = port;
            random_bits(`ETH_DATA_WIDTH, r);
            want.data = r[`ETH_DATA_WIDTH-1:0];
            random_bits(`ETH_KEEP_WIDTH, r);
            want.keep = r[`ETH_KEEP_WIDTH-1:0];
            want.last = (beat == nbeats - 1);
            in_tdata = want.data;
            in_tkeep = want.keep;
            in_tlast = want.last;
            in_tvalid = 1'b1;
            beat_q.push_back(want);
            count = 0;
            while (!in_tready && count < TIMEOUT) begin
                next_cycle();
                count++;
            end
            if (!in_tready) begin
                timed_out = 1'b1;
                $display("timeout: payload beat %0d not accepted within %0d cycles", beat,
                         TIMEOUT);
            end else begin
                next_cycle();
            end
        end
        in_tvalid = 1'b0;
    endtask

    task automatic send_frame();
        logic [63:0]               r;
        logic [`ETH_SEL_WIDTH-1:0] port;
        int                        nbeats;
        random_bits(`ETH_SEL_WIDTH, r);
        port = r[`ETH_SEL_WIDTH-1:0];
        random_bits(3, r);
        nbeats = int'(r[2:0]) + 1;
        present_header(port);
        await_header();
        if (!timed_out) begin
            send_payload(port, nbeats, 1'b1);
        end
    endtask

    task automatic wait_drained();
        int count;
        count = 0;
        while ((hdr_q.size() != 0 || beat_q.size() != 0) && count < 4 * TIMEOUT) begin
            next_cycle();
            count++;
        end
        if (hdr_q.size() != 0 || beat_q.size() != 0) begin
            timed_out = 1'b1;
            $display("timeout: %0d headers and %0d beats never left the outputs",
                     hdr_q.size(), beat_q.size());
        end
    endtask

    task automatic report_test(input string name, input int start_errors);
        tests_run++;
        if (error_count != start_errors || timed_out) begin
            tests_failed++;
            $display("test %s: FAIL, %0d errors", name, error_count - start_errors);
        end else begin
            $display("test %s: pass", name);
        end
    endtask

    task automatic expect_reset_state();
        int start_errors;
        int count;
        start_errors = error_count;
        count = 0;
        // state left by the first reset edge, before rst is released
        @(posedge clk);
        @(negedge clk);
        if (in_hdr_ready || in_tready || out_hdr_valid != '0 || out_tvalid != '0) begin
            log_error("handshake outputs not low during reset");
        end
        do begin
            @(posedge clk);
            count++;
        end while (rst !== 1'b0 && count < 10);
        if (rst !== 1'b0) begin
            timed_out = 1'b1;
            $display("timeout: reset was never released");
        end else begin
            next_cycle();
            if (in_hdr_ready || in_tready || out_hdr_valid != '0 || out_tvalid != '0) begin
                log_error("handshake outputs not low after reset");
            end
        end
        report_test("reset", start_errors);
    endtask

    task automatic route_random_frames(input string name, input int nframes);
        int start_errors;
        int i;
        start_errors = error_count;
        for (i = 0; i < nframes && !timed_out; i++) begin
            send_frame();
        end
        if (!timed_out) begin
            wait_drained();
        end
        random_ready = 1'b0;
        report_test(name, start_errors);
    endtask

    task automatic hold_headers_off();
        int start_errors;
        int i;
        start_errors = error_count;
        wait_drained();
        if (!timed_out) begin
            enable = 1'b0;
            present_header(2'd2);
            for (i = 0; i < 16; i++) begin
                next_cycle();
                if (in_hdr_ready || out_hdr_valid != '0) begin
                    log_error("header granted while enable is low");
                end
            end
            enable = 1'b1;
            await_header();
            if (!timed_out) begin
                send_payload(2'd2, 3, 1'b0);
            end
            for (i = 0; i < 3 && !timed_out; i++) begin
                send_frame();
            end
            if (!timed_out) begin
                wait_drained();
            end
        end
        report_test("enable", start_errors);
    endtask

    initial begin
        enable = 1'b1;
        select = '0;
        in_hdr_valid = 1'b0;
        in_dest_mac = '0;
        in_src_mac = '0;
        in_eth_type = '0;
        in_tdata = '0;
        in_tkeep = '0;
        in_tvalid = 1'b0;
        in_tlast = 1'b0;
        out_hdr_ready = '0;
        out_tready = '0;

        expect_reset_state();
        if (!timed_out) begin
            route_random_frames("routing", 24);
        end
        if (!timed_out) begin
            hold_headers_off();
        end
        if (!timed_out) begin
            random_ready = 1'b1;
            route_random_frames("back-pressure", 40);
        end
        if (!timed_out) begin
            tests_run++;
            if (excl_errors != 0) begin
                tests_failed++;
                $display("test exclusivity: FAIL, %0d errors", excl_errors);
            end else begin
                $display("test exclusivity: pass over %0d cycles", cycle_count);
            end
        end

        $display("tests %0d, failed %0d, errors %0d, headers %0d, beats %0d", tests_run,
                 tests_failed, error_count, hdrs_checked, beats_checked);
        if (error_count == 0 && tests_failed == 0 && !timed_out) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== files.f ====
+incdir+verilog
verilog/eth_hdr_pkg.sv
verilog/eth_stream_pkg.sv
verilog/eth_port_if.sv
verilog/eth_frame_ctrl.sv
verilog/eth_beat_skid.sv
verilog/eth_port_ctrl.sv
verilog/eth_demux_top.sv
verification/tb_clk_gen.sv
verification/tb_eth_demux.sv

// ==== run.sh ====
#!/usr/bin/env bash
# build and run the Ethernet demultiplexer testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --timescale 1ns/1ps \
    -f files.f --top-module tb_eth_demux -o sim_eth_demux

./obj_dir/sim_eth_demux | tee sim.log

if grep -qx "Simulation PASSED" sim.log; then
    exit 0
else
    exit 1
fi
